// File: build.f
source/busPkg.sv
source/displayPkg.sv
source/glyphEncoder.sv
source/hostBridge.sv
source/busDecoder.sv
source/scratchRam.sv
source/segmentDisplay.sv
source/sevenSegSystem.sv
testbench/tbClock.sv
testbench/sevenSegSystem_props.sv
testbench/sevenSegSystem_tb.sv

// File: build.sh
#!/usr/bin/env bash
# compile with Verilator, run, and decide on the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module sevenSegSystem_tb -f build.f -o simv \
    || { echo "compile failed"; exit 1; }
out="$(./obj_dir/simv 2>&1)"
echo "$out"
grep -qxF '=== PASS ===' <<< "$out" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: source/busDecoder.sv
// address decoder for the internal bus, selects RAM or display and muxes read data back
`default_nettype none
`timescale 1ns/1ps

module busDecoder #(
    parameter busPkg::busAddr_t DISPLAY_BASE  = busPkg::DEFAULT_DISPLAY_BASE,
    parameter int               RAM_ADDR_BITS = busPkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic                  clk,
    input  wire logic                  nrst,
    input  wire logic                  busStrobe,
    input  wire busPkg::busAddr_t      busAddr,
    output logic                       ramSel,
    output logic                       dispSel,
    output displayPkg::digitIndex_t    dispIndex,
    input  wire busPkg::busData_t      ramRdata,
    input  wire busPkg::busData_t      dispRdata,
    output busPkg::busData_t           busRdata
);

    localparam int RAM_SIZE   = 1 << RAM_ADDR_BITS;
    localparam int DISP_START = int'(DISPLAY_BASE);
    localparam int DISP_END   = DISP_START + displayPkg::NUM_DIGITS;

    // RAM sits at 0, so the display must start at or above its top
    if (DISP_START < RAM_SIZE) begin : gOverlap
        $error("display range overlaps scratch RAM range");
    end

    logic             ramHit;
    logic             dispHit;
    logic             ramSelQ;
    logic             dispSelQ;
    busPkg::busAddr_t dispOffset;

    assign ramHit  = int'(busAddr) < RAM_SIZE;
    assign dispHit = int'(busAddr) >= DISP_START && int'(busAddr) < DISP_END;

    assign ramSel  = busStrobe && ramHit;
    assign dispSel = busStrobe && dispHit;

    // low bits of the offset pick the digit
    assign dispOffset = busAddr - DISPLAY_BASE;
    assign dispIndex  = displayPkg::digitIndex_t'(dispOffset);

    // remember which target answers in the cycle after the strobe
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            ramSelQ  <= 1'b0;
            dispSelQ <= 1'b0;
        end else begin
            ramSelQ  <= ramSel;
            dispSelQ <= dispSel;
        end
    end

    // unmapped reads fall through to zero
    assign busRdata = ramSelQ  ? ramRdata  :
                      dispSelQ ? dispRdata : '0;

endmodule

`default_nettype wire

// File: source/busPkg.sv
// bus-level types and memory map defaults shared by the bridge, decoder and top level
`default_nettype none

package busPkg;

    // byte address, high byte and low byte of the processor bus side by side
    typedef logic [15:0] busAddr_t;

    // one data byte on the bus
    typedef logic [7:0] busData_t;

    // host bridge FSM states
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESPOND,
        RELEASE
    } bridgeState_t;

    // first address of the digit registers
    localparam busAddr_t DEFAULT_DISPLAY_BASE = 16'h0100;

    // 8 bits of RAM address, so 256 bytes starting at 0x0000
    localparam int DEFAULT_RAM_ADDR_BITS = 8;

endpackage

`default_nettype wire

// File: source/displayPkg.sv
// display-side types: digit count, glyph codes, segment patterns and digit selects
`default_nettype none

package displayPkg;

    // digits on the board, each driven statically from its own port
    localparam int NUM_DIGITS = 8;

    // code written by the host into a digit register
    // 0..15 hex digits, 16..19 the letters H w o r
    typedef logic [7:0] glyphCode_t;

    // segment enables, one bit per segment
    //   bit 0 = a
    //   bit 1 = b
    //   bit 2 = c
    //   bit 3 = d
    //   bit 4 = e
    //   bit 5 = f
    //   bit 6 = g
    //   bit 7 unused, always zero from the encoder
    typedef logic [7:0] segPattern_t;

    // selects one of the NUM_DIGITS registers
    typedef logic [2:0] digitIndex_t;

endpackage

`default_nettype wire

// File: source/glyphEncoder.sv
// combinational table from a host glyph code to a seven-segment pattern
`default_nettype none
`timescale 1ns/1ps

module glyphEncoder (
    input  wire displayPkg::glyphCode_t code,
    output displayPkg::segPattern_t     pattern
);

    // segments a-f lit, the digit 0
    localparam displayPkg::segPattern_t ZERO = 8'h3F;

    always_comb begin
        case (code)
            8'd0:    pattern = ZERO;
            8'd1:    pattern = 8'h06;
            8'd2:    pattern = 8'h5B;
            8'd3:    pattern = 8'h4F;
            8'd4:    pattern = 8'h66;
            8'd5:    pattern = 8'h6D;
            8'd6:    pattern = 8'h7D;
            8'd7:    pattern = 8'h07;
            8'd8:    pattern = 8'h7F;
            8'd9:    pattern = 8'h6F;
            8'd10:   pattern = 8'h77;
            // lower case b and d so they differ from 8 and 0
            8'd11:   pattern = 8'h7C;
            8'd12:   pattern = 8'h39;
            8'd13:   pattern = 8'h5E;
            8'd14:   pattern = 8'h79;
            8'd15:   pattern = 8'h71;
            // letters
            8'd16:   pattern = 8'h76;
            8'd17:   pattern = 8'h3E;
            8'd18:   pattern = 8'h5C;
            8'd19:   pattern = 8'h50;
            // unknown codes show 0
            default: pattern = ZERO;
        endcase
    end

endmodule

`default_nettype wire

// File: source/hostBridge.sv
// four-phase req/ack slave that turns each host request into one single-cycle bus access
`default_nettype none
`timescale 1ns/1ps

module hostBridge (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             req,
    input  wire logic             we,
    input  wire busPkg::busAddr_t addr,
    input  wire busPkg::busData_t wdata,
    output logic                  ack,
    output busPkg::busData_t      rdata,
    output logic                  busStrobe,
    output logic                  busWrite,
    output busPkg::busAddr_t      busAddr,
    output busPkg::busData_t      busWdata,
    input  wire busPkg::busData_t busRdata
);

    busPkg::bridgeState_t state;

    // strobe lasts exactly the one cycle spent in ACCESS
    assign busStrobe = (state == busPkg::ACCESS);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state <= busPkg::IDLE;
            ack   <= 1'b0;
        end else begin
            case (state)
                busPkg::IDLE: begin
                    if (req) begin
                        state <= busPkg::ACCESS;
                    end
                end
                busPkg::ACCESS: begin
                    state <= busPkg::RESPOND;
                end
                busPkg::RESPOND: begin
                    // target data arrives now; ack stays up while req is held
                    if (!ack) begin
                        ack <= 1'b1;
                    end else if (!req) begin
                        state <= busPkg::RELEASE;
                    end
                end
                busPkg::RELEASE: begin
                    ack   <= 1'b0;
                    state <= busPkg::IDLE;
                end
                default: begin
                    state <= busPkg::IDLE;
                end
            endcase
        end
    end

    // request fields are stable while req is high, latch them on the way to ACCESS
    always_ff @(posedge clk) begin
        if (state == busPkg::IDLE && req) begin
            busAddr  <= addr;
            busWrite <= we;
            busWdata <= wdata;
        end
        // capture once, in the same edge that raises ack
        if (state == busPkg::RESPOND && !ack) begin
            rdata <= busRdata;
        end
    end

endmodule

`default_nettype wire

// File: source/scratchRam.sv
// byte-wide scratch RAM on the internal bus, synchronous write and registered read
`default_nettype none
`timescale 1ns/1ps

module scratchRam #(
    parameter int RAM_ADDR_BITS = busPkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic                     clk,
    input  wire logic                     sel,
    input  wire logic                     write,
    input  wire logic [RAM_ADDR_BITS-1:0] addr,
    input  wire busPkg::busData_t         wdata,
    output busPkg::busData_t              rdata
);

    localparam int DEPTH = 1 << RAM_ADDR_BITS;

    busPkg::busData_t mem [DEPTH];

    // contents are undefined after power-up
    always_ff @(posedge clk) begin
        if (sel && write) begin
            mem[addr] <= wdata;
        end
    end

    // read data shows up the cycle after the strobe
    always_ff @(posedge clk) begin
        if (sel && !write) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: source/segmentDisplay.sv
// eight digit registers holding segment patterns, loaded through the glyph encoder
`default_nettype none
`timescale 1ns/1ps

module segmentDisplay (
    input  wire logic                    clk,
    input  wire logic                    nrst,
    input  wire logic                    sel,
    input  wire logic                    write,
    input  wire displayPkg::digitIndex_t index,
    input  wire busPkg::busData_t        wdata,
    output busPkg::busData_t             rdata,
    output displayPkg::segPattern_t      ss0,
    output displayPkg::segPattern_t      ss1,
    output displayPkg::segPattern_t      ss2,
    output displayPkg::segPattern_t      ss3,
    output displayPkg::segPattern_t      ss4,
    output displayPkg::segPattern_t      ss5,
    output displayPkg::segPattern_t      ss6,
    output displayPkg::segPattern_t      ss7
);

    displayPkg::segPattern_t encoded;
    displayPkg::segPattern_t segs [displayPkg::NUM_DIGITS];

    glyphEncoder encoder_i (
        .code    (wdata),
        .pattern (encoded)
    );

    // only the addressed digit changes, all others hold
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < displayPkg::NUM_DIGITS; i++) begin
                segs[i] <= '0;
            end
        end else if (sel && write) begin
            segs[index] <= encoded;
        end
    end

    // readback returns the stored pattern, not the code
    always_ff @(posedge clk) begin
        if (sel && !write) begin
            rdata <= segs[index];
        end
    end

    // digits are driven statically, no scanning
    assign ss0 = segs[0];
    assign ss1 = segs[1];
    assign ss2 = segs[2];
    assign ss3 = segs[3];
    assign ss4 = segs[4];
    assign ss5 = segs[5];
    assign ss6 = segs[6];
    assign ss7 = segs[7];

endmodule

`default_nettype wire

// File: source/sevenSegSystem.sv
// top level of the display subsystem: host bridge, decoder, scratch RAM and digit block
`default_nettype none
`timescale 1ns/1ps

module sevenSegSystem #(
    parameter busPkg::busAddr_t DISPLAY_BASE  = busPkg::DEFAULT_DISPLAY_BASE,
    parameter int               RAM_ADDR_BITS = busPkg::DEFAULT_RAM_ADDR_BITS
) (
    input  wire logic               clk,
    input  wire logic               nrst,
    input  wire logic               req,
    input  wire logic               we,
    input  wire busPkg::busAddr_t   addr,
    input  wire busPkg::busData_t   wdata,
    output logic                    ack,
    output busPkg::busData_t        rdata,
    output displayPkg::segPattern_t ss0,
    output displayPkg::segPattern_t ss1,
    output displayPkg::segPattern_t ss2,
    output displayPkg::segPattern_t ss3,
    output displayPkg::segPattern_t ss4,
    output displayPkg::segPattern_t ss5,
    output displayPkg::segPattern_t ss6,
    output displayPkg::segPattern_t ss7
);

    logic                    busStrobe;
    logic                    busWrite;
    busPkg::busAddr_t        busAddr;
    busPkg::busData_t        busWdata;
    busPkg::busData_t        busRdata;
    logic                    ramSel;
    logic                    dispSel;
    displayPkg::digitIndex_t dispIndex;
    busPkg::busData_t        ramRdata;
    busPkg::busData_t        dispRdata;

    hostBridge bridge_i (
        .clk       (clk),
        .nrst      (nrst),
        .req       (req),
        .we        (we),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .busStrobe (busStrobe),
        .busWrite  (busWrite),
        .busAddr   (busAddr),
        .busWdata  (busWdata),
        .busRdata  (busRdata)
    );

    busDecoder #(
        .DISPLAY_BASE  (DISPLAY_BASE),
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) decoder_i (
        .clk       (clk),
        .nrst      (nrst),
        .busStrobe (busStrobe),
        .busAddr   (busAddr),
        .ramSel    (ramSel),
        .dispSel   (dispSel),
        .dispIndex (dispIndex),
        .ramRdata  (ramRdata),
        .dispRdata (dispRdata),
        .busRdata  (busRdata)
    );

    // RAM sees only the low address bits, the decoder already checked the rest
    scratchRam #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) ram_i (
        .clk   (clk),
        .sel   (ramSel),
        .write (busWrite),
        .addr  (busAddr[RAM_ADDR_BITS-1:0]),
        .wdata (busWdata),
        .rdata (ramRdata)
    );

    segmentDisplay display_i (
        .clk   (clk),
        .nrst  (nrst),
        .sel   (dispSel),
        .write (busWrite),
        .index (dispIndex),
        .wdata (busWdata),
        .rdata (dispRdata),
        .ss0   (ss0),
        .ss1   (ss1),
        .ss2   (ss2),
        .ss3   (ss3),
        .ss4   (ss4),
        .ss5   (ss5),
        .ss6   (ss6),
        .ss7   (ss7)
    );

endmodule

`default_nettype wire

// File: testbench/sevenSegSystem_props.sv
// handshake and digit output assertions bound to the display subsystem top level
`default_nettype none
`timescale 1ns/1ps

module sevenSegSystem_props #(
    parameter busPkg::busAddr_t DISPLAY_BASE = busPkg::DEFAULT_DISPLAY_BASE
) (
    input wire logic                    clk,
    input wire logic                    nrst,
    input wire logic                    req,
    input wire logic                    we,
    input wire busPkg::busAddr_t        addr,
    input wire busPkg::busData_t        wdata,
    input wire logic                    ack,
    input wire displayPkg::segPattern_t ss0,
    input wire displayPkg::segPattern_t ss1,
    input wire displayPkg::segPattern_t ss2,
    input wire displayPkg::segPattern_t ss3,
    input wire displayPkg::segPattern_t ss4,
    input wire displayPkg::segPattern_t ss5,
    input wire displayPkg::segPattern_t ss6,
    input wire displayPkg::segPattern_t ss7
);

    // reference patterns for codes 0 to 19 with segment a in bit 0
    localparam displayPkg::segPattern_t GLYPHS [20] = '{
        8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07, 8'h7F, 8'h6F,
        8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71, 8'h76, 8'h3E, 8'h5C, 8'h50
    };

    logic [63:0] digits;

    assign digits = {ss7, ss6, ss5, ss4, ss3, ss2, ss1, ss0};

    // whole digit bank expected after one host write
    function automatic logic [63:0] afterWrite(input logic [63:0] old,
                                               input busPkg::busAddr_t a,
                                               input displayPkg::glyphCode_t c);
        logic [63:0] res;
        int          k;
        res = old;
        k   = int'(a) - int'(DISPLAY_BASE);
        if (k >= 0 && k < displayPkg::NUM_DIGITS) begin
            res[8*k +: 8] = (c < 8'd20) ? GLYPHS[c[4:0]] : 8'h3F;
        end
        return res;
    endfunction

    resetState: assert property (@(posedge clk) $rose(nrst) |-> !ack && digits == 64'h0)
        else $error("ack or a digit output not cleared by reset");

    // ack is set two edges after req is seen and first sampled high one edge later
    ackRise: assert property (@(posedge clk) disable iff (!nrst)
        $rose(req) |-> !ack ##1 !ack ##1 !ack ##1 ack)
        else $error("ack did not rise two edges after req");

    ackFall: assert property (@(posedge clk) disable iff (!nrst)
        $fell(req) |-> ack ##1 ack ##1 !ack)
        else $error("ack did not fall one edge after req");

    ackNeedsReq: assert property (@(posedge clk) disable iff (!nrst)
        $rose(ack) |-> $past(req))
        else $error("ack rose without a pending request");

    // only the addressed digit may change and it already shows the table pattern when ack rises
    digitWrite: assert property (@(posedge clk) disable iff (!nrst)
        $rose(req) && we |->
            ##2 digits == afterWrite($past(digits, 2), $past(addr, 2), $past(wdata, 2)))
        else $error("digit outputs wrong after a write");

endmodule

`default_nettype wire

// File: testbench/sevenSegSystem_tb.sv
// runs host transfers on the display subsystem and checks read data against shadow copies
`default_nettype none
`timescale 1ns/1ps

module sevenSegSystem_tb;

    localparam busPkg::busAddr_t DISPLAY_BASE  = busPkg::DEFAULT_DISPLAY_BASE;
    localparam int               RAM_ADDR_BITS = busPkg::DEFAULT_RAM_ADDR_BITS;
    localparam int               RAM_SIZE      = 1 << RAM_ADDR_BITS;
    localparam int               CLK_PERIOD_NS = 4;
    localparam int               NUM_UNMAPPED  = 10;
    localparam int               NUM_MIXED     = 200;
    // glyph sweep, odd codes, RAM fill, unmapped, mixed RAM traffic, digits after reset
    localparam int NUM_TRANSFERS = 40 + 16 + RAM_SIZE + 3 * NUM_UNMAPPED + NUM_MIXED + 8;
    localparam int WATCHDOG_NS   = NUM_TRANSFERS * 20 * CLK_PERIOD_NS + 200;

    localparam displayPkg::segPattern_t GLYPHS [20] = '{
        8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07, 8'h7F, 8'h6F,
        8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71, 8'h76, 8'h3E, 8'h5C, 8'h50
    };

    logic                    clk;
    logic                    nrst;
    logic                    resetReq;
    logic                    req;
    logic                    we;
    logic                    ack;
    busPkg::busAddr_t        addr;
    busPkg::busData_t        wdata;
    busPkg::busData_t        rdata;
    displayPkg::segPattern_t ss0;
    displayPkg::segPattern_t ss1;
    displayPkg::segPattern_t ss2;
    displayPkg::segPattern_t ss3;
    displayPkg::segPattern_t ss4;
    displayPkg::segPattern_t ss5;
    displayPkg::segPattern_t ss6;
    displayPkg::segPattern_t ss7;
    logic [15:0]             lfsr = 16'd45808;
    busPkg::busData_t        ramShadow [RAM_SIZE];
    displayPkg::segPattern_t digitShadow [displayPkg::NUM_DIGITS];

    tbClock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(5)) clock_i (
        .resetReq (resetReq),
        .clk      (clk),
        .nrst     (nrst)
    );

    sevenSegSystem #(.DISPLAY_BASE(DISPLAY_BASE), .RAM_ADDR_BITS(RAM_ADDR_BITS)) dut_i (.*);

    bind sevenSegSystem sevenSegSystem_props #(.DISPLAY_BASE(DISPLAY_BASE)) props_i (
        .clk   (clk),
        .nrst  (nrst),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .ss0   (ss0),
        .ss1   (ss1),
        .ss2   (ss2),
        .ss3   (ss3),
        .ss4   (ss4),
        .ss5   (ss5),
        .ss6   (ss6),
        .ss7   (ss7)
    );

    // Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] nextLfsr(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = nextLfsr(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    function automatic displayPkg::segPattern_t expectedGlyph(input displayPkg::glyphCode_t c);
        return (c < 8'd20) ? GLYPHS[c[4:0]] : 8'h3F;
    endfunction

    function automatic busPkg::busAddr_t digitAddr(input int k);
        return DISPLAY_BASE + 16'(k);
    endfunction

    function automatic logic isMapped(input busPkg::busAddr_t a);
        return int'(a) < RAM_SIZE || (int'(a) >= int'(DISPLAY_BASE)
            && int'(a) < int'(DISPLAY_BASE) + displayPkg::NUM_DIGITS);
    endfunction

    // one four-phase transfer that starts and ends on a falling edge
    task automatic transfer(input logic isWrite, input busPkg::busAddr_t a,
                            input busPkg::busData_t d, output busPkg::busData_t got);
        logic [15:0] gap;
        takeBits(2, gap);
        repeat (gap[1:0]) @(negedge clk);
        req   = 1'b1;
        we    = isWrite;
        addr  = a;
        wdata = d;
        while (!ack) @(negedge clk);
        got = rdata;
        req = 1'b0;
        while (ack) @(negedge clk);
    endtask

    task automatic checkRead(input busPkg::busAddr_t a, input busPkg::busData_t expected);
        busPkg::busData_t got;
        transfer(1'b0, a, 8'h00, got);
        rdataMatch: assert (got == expected) else begin
            $display("error at %0d ns: rdata from 0x%04h is 0x%02h, expected 0x%02h",
                     $time, a, got, expected);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic writeDigit(input int k, input displayPkg::glyphCode_t code);
        busPkg::busData_t got;
        transfer(1'b1, digitAddr(k), code, got);
        digitShadow[k] = expectedGlyph(code);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the transfers did not finish in the allowed time");
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        busPkg::busData_t got;
        busPkg::busAddr_t a;
        logic [15:0]      r;
        logic [15:0]      d;
        int               k;
        req      = 1'b0;
        we       = 1'b0;
        addr     = '0;
        wdata    = '0;
        resetReq = 1'b0;
        for (int i = 0; i < displayPkg::NUM_DIGITS; i++) digitShadow[i] = '0;
        @(posedge nrst);
        @(negedge clk);

        // every table code once and read back from its digit
        for (int c = 0; c < 20; c++) begin
            k = c % displayPkg::NUM_DIGITS;
            writeDigit(k, 8'(c));
            checkRead(digitAddr(k), digitShadow[k]);
        end

        // codes past the table
        for (int i = 0; i < 8; i++) begin
            takeBits(8, r);
            if (r[7:0] < 8'd20) r[7:0] = r[7:0] + 8'd20;
            takeBits(3, d);
            writeDigit(int'(d[2:0]), r[7:0]);
        end
        for (int i = 0; i < displayPkg::NUM_DIGITS; i++) checkRead(digitAddr(i), digitShadow[i]);

        for (int i = 0; i < RAM_SIZE; i++) begin
            takeBits(8, r);
            transfer(1'b1, 16'(i), r[7:0], got);
            ramShadow[i] = r[7:0];
        end

        // unmapped writes must not alias into RAM
        for (int i = 0; i < NUM_UNMAPPED; i++) begin
            takeBits(16, r);
            a = (i == 0) ? digitAddr(displayPkg::NUM_DIGITS) : r;
            if (isMapped(a)) a[15] = ~a[15];
            takeBits(8, d);
            transfer(1'b1, a, d[7:0], got);
            checkRead(a, 8'h00);
            checkRead(16'(a[RAM_ADDR_BITS-1:0]), ramShadow[a[RAM_ADDR_BITS-1:0]]);
        end

        for (int i = 0; i < NUM_MIXED; i++) begin
            takeBits(RAM_ADDR_BITS, r);
            a = 16'(r[RAM_ADDR_BITS-1:0]);
            takeBits(1, d);
            if (d[0]) begin
                takeBits(8, d);
                transfer(1'b1, a, d[7:0], got);
                ramShadow[r[RAM_ADDR_BITS-1:0]] = d[7:0];
            end else begin
                checkRead(a, ramShadow[r[RAM_ADDR_BITS-1:0]]);
            end
        end

        // second reset while idle clears the digits
        resetReq = 1'b1;
        repeat (3) @(negedge clk);
        resetReq = 1'b0;
        for (int i = 0; i < displayPkg::NUM_DIGITS; i++) digitShadow[i] = '0;
        for (int i = 0; i < displayPkg::NUM_DIGITS; i++) checkRead(digitAddr(i), digitShadow[i]);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tbClock.sv
// testbench clock and reset source, power-on reset plus a reset request input for mid-run resets
`default_nettype none
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 5
) (
    input  wire logic resetReq,
    output logic      clk,
    output wire logic nrst
);

    logic porActive;

    assign nrst = !(porActive || resetReq);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // nrst starts high so power-on reset is a real falling edge
    initial begin
        porActive = 1'b0;
        #1;
        porActive = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        porActive = 1'b0;
    end

endmodule

`default_nettype wire
